// File: common/conv_pkg.sv
package conv_pkg;

	// --------------------
	// datapath widths
	localparam int DATA_W = 8;
	localparam int PROD_W = 16;
	localparam int ACC_W  = 20;
	localparam int OUT_W  = 16;
	localparam int SIZE_W = 4;
	localparam int ADDR_W = 6;

	// --------------------
	// kernel and image geometry
	localparam int KERNEL      = 3;
	localparam int TAPS        = KERNEL * KERNEL;
	localparam int IMG_MIN     = 3;
	localparam int IMG_MAX     = 8;
	localparam int FRAME_DEPTH = IMG_MAX * IMG_MAX;
	localparam int COORD_W     = $clog2(IMG_MAX);
	localparam int IDX_W       = $clog2(TAPS);

	// --------------------
	// activation and saturation
	localparam int LEAK_DIV = 10;
	localparam int OUT_MAX  = 32767;
	localparam int OUT_MIN  = -32768;

	// controller states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_FILT = 2'd1;
	localparam logic [1:0] ST_IMG  = 2'd2;
	localparam logic [1:0] ST_SCAN = 2'd3;

endpackage

// File: conv_ctrl/conv_ctrl.sv
`timescale 1ns/10ps

module conv_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         filter_valid,
	input  logic                         image_valid,
	input  logic [conv_pkg::SIZE_W-1:0]  image_size,
	input  logic                         pad_mode,
	input  logic                         act_mode,
	output logic                         coef_we,
	output logic [conv_pkg::IDX_W-1:0]   coef_idx,
	output logic                         pix_we,
	output logic [conv_pkg::ADDR_W-1:0]  pix_addr,
	output logic                         scan_valid,
	output logic [conv_pkg::COORD_W-1:0] scan_row,
	output logic [conv_pkg::COORD_W-1:0] scan_col,
	output logic [conv_pkg::SIZE_W-1:0]  size_reg,
	output logic                         pad_reg,
	output logic                         act_reg
);
	import conv_pkg::*;

	logic [1:0]         state;
	logic [ADDR_W-1:0]  load_cnt;
	logic [COORD_W-1:0] row_cnt;
	logic [COORD_W-1:0] col_cnt;
	logic [ADDR_W:0]    pix_total;
	logic               last_coef;
	logic               last_pix;
	logic               last_col;
	logic               last_row;

	assign pix_total = size_reg * size_reg;
	assign last_coef = (load_cnt == ADDR_W'(TAPS - 1));
	assign last_pix  = ({1'b0, load_cnt} == pix_total - 1'b1);
	assign last_col  = (col_cnt == size_reg - 1'b1);
	assign last_row  = (row_cnt == size_reg - 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			load_cnt   <= '0;
			row_cnt    <= '0;
			col_cnt    <= '0;
			coef_we    <= 1'b0;
			coef_idx   <= '0;
			pix_we     <= 1'b0;
			pix_addr   <= '0;
			scan_valid <= 1'b0;
			scan_row   <= '0;
			scan_col   <= '0;
			size_reg   <= SIZE_W'(IMG_MIN);
			pad_reg    <= 1'b0;
			act_reg    <= 1'b0;
		end else begin
			// strobes default low
			coef_we    <= 1'b0;
			pix_we     <= 1'b0;
			scan_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (filter_valid) begin
						// config rides on the first coefficient
						size_reg <= image_size;
						pad_reg  <= pad_mode;
						act_reg  <= act_mode;
						coef_we  <= 1'b1;
						coef_idx <= '0;
						load_cnt <= ADDR_W'(1);
						state    <= ST_FILT;
					end else if (image_valid) begin
						pix_we   <= 1'b1;
						pix_addr <= '0;
						load_cnt <= ADDR_W'(1);
						state    <= ST_IMG;
					end
				end
				ST_FILT: begin
					if (filter_valid) begin
						coef_we  <= 1'b1;
						coef_idx <= IDX_W'(load_cnt);
						load_cnt <= load_cnt + 1'b1;
						if (last_coef)
							state <= ST_IDLE;
					end
				end
				ST_IMG: begin
					if (image_valid) begin
						pix_we   <= 1'b1;
						pix_addr <= load_cnt;
						load_cnt <= load_cnt + 1'b1;
						if (last_pix) begin
							row_cnt <= '0;
							col_cnt <= '0;
							state   <= ST_SCAN;
						end
					end
				end
				ST_SCAN: begin
					// one window per cycle, raster order
					scan_valid <= 1'b1;
					scan_row   <= row_cnt;
					scan_col   <= col_cnt;
					if (last_col) begin
						col_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
						if (last_row)
							state <= ST_IDLE;
					end else begin
						col_cnt <= col_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: conv_frame/conv_frame.sv
`timescale 1ns/10ps

module conv_frame (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         pix_we,
	input  logic [conv_pkg::ADDR_W-1:0]                  pix_addr,
	input  logic signed [conv_pkg::DATA_W-1:0]           in_data,
	input  logic                                         scan_valid,
	input  logic [conv_pkg::COORD_W-1:0]                 scan_row,
	input  logic [conv_pkg::COORD_W-1:0]                 scan_col,
	input  logic [conv_pkg::SIZE_W-1:0]                  size_reg,
	input  logic                                         pad_reg,
	output logic                                         win_valid,
	output logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0]   window
);
	import conv_pkg::*;

	logic signed [DATA_W-1:0] frame [FRAME_DEPTH];
	logic signed [DATA_W-1:0] pix_q;
	logic [TAPS*DATA_W-1:0]   win_nxt;

	// neighbour coordinate inside the image
	function automatic logic coord_ok(input logic signed [COORD_W+1:0] v,
	                                  input logic [SIZE_W-1:0] n);
		return (v >= 0) && (v < $signed({1'b0, n}));
	endfunction

	// nearest edge coordinate
	function automatic logic [COORD_W-1:0] clamp_coord(input logic signed [COORD_W+1:0] v,
	                                                   input logic [SIZE_W-1:0] n);
		if (v < 0)
			return '0;
		if (v >= $signed({1'b0, n}))
			return COORD_W'(n - 1'b1);
		return v[COORD_W-1:0];
	endfunction

	// pixel delayed to meet the registered write strobe
	always_ff @(posedge clk) begin
		pix_q <= in_data;
		if (pix_we)
			frame[pix_addr] <= pix_q;
	end

	// --------------------
	// 3x3 gather around (scan_row, scan_col)
	always_comb begin : gather
		logic signed [COORD_W+1:0] nr;
		logic signed [COORD_W+1:0] nc;
		logic [COORD_W-1:0]        rc;
		logic [COORD_W-1:0]        cc;
		logic [ADDR_W-1:0]         addr;
		logic                      in_img;
		win_nxt = '0;
		for (int dr = 0; dr < KERNEL; dr++) begin
			for (int dc = 0; dc < KERNEL; dc++) begin
				nr     = (COORD_W + 2)'($signed({2'b00, scan_row}) + dr - 1);
				nc     = (COORD_W + 2)'($signed({2'b00, scan_col}) + dc - 1);
				rc     = clamp_coord(nr, size_reg);
				cc     = clamp_coord(nc, size_reg);
				in_img = coord_ok(nr, size_reg) && coord_ok(nc, size_reg);
				addr   = rc * size_reg + cc;
				// border reads 0 unless replicating
				win_nxt[(dr*KERNEL + dc)*DATA_W +: DATA_W] =
					(in_img || pad_reg) ? frame[addr] : '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan_valid)
			window <= win_nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			win_valid <= 1'b0;
		else
			win_valid <= scan_valid;
	end

endmodule

// File: project.f
common/conv_pkg.sv
conv_ctrl/conv_ctrl.sv
conv_frame/conv_frame.sv
verilog/conv_mac.sv
verilog/conv_act.sv
verilog/conv_top.sv
sim/conv_props.sv
sim/conv_tb.sv

// File: run.sh
#!/bin/sh
# compile conv_tb with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
	-f project.f -o conv_tb_sim > build.log 2>&1 \
	&& ./obj_dir/conv_tb_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "Verification passed" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: sim/conv_props.sv
`timescale 1ns/10ps

module conv_props (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              out_valid,
	input logic signed [conv_pkg::OUT_W-1:0] out_data,
	input logic                              scan_valid,
	input logic                              pix_we
);
	import conv_pkg::*;

	// no output while in reset
	out_low_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high while reset is active");

	idle_data_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out_data == '0))
		else $error("out_data nonzero while out_valid is low");

	// frame writes and window scan never share a cycle
	scan_load_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(scan_valid && pix_we))
		else $error("scan_valid and pix_we high together");

endmodule

bind conv_top conv_props conv_props_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_data   (out_data),
	.scan_valid (scan_valid),
	.pix_we     (pix_we)
);

// File: sim/conv_tb.sv
`timescale 1ns/10ps

module conv_tb;
	import conv_pkg::*;

	localparam int CLK_PERIOD = 10;
	// frame sides in test order, used for the watchdog budget
	localparam int FRAME_SIDES [10] = '{5, 6, 4, 4, 3, 3, 8, 8, 7, 7};

	logic                     clk;
	logic                     rst_n;
	logic                     filter_valid;
	logic                     image_valid;
	logic [SIZE_W-1:0]        image_size;
	logic                     pad_mode;
	logic                     act_mode;
	logic signed [DATA_W-1:0] in_data;
	logic                     out_valid;
	logic signed [OUT_W-1:0]  out_data;

	// reference copies of the loaded filter, image and config
	logic signed [DATA_W-1:0] filt [TAPS];
	logic signed [DATA_W-1:0] img [FRAME_DEPTH];
	int                       cfg_n;
	bit                       cfg_pad;
	bit                       cfg_act;
	logic [31:0]              rng;
	logic signed [OUT_W-1:0]  exp_q [$];
	string                    test_name;
	int                       word_cnt;

	conv_top conv_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// expected output pixel at (r, c) of the stored frame
	function automatic logic signed [OUT_W-1:0] conv_ref(input int r, input int c);
		int acc;
		int nr;
		int nc;
		int px;
		acc = 0;
		for (int dr = 0; dr < KERNEL; dr++) begin
			for (int dc = 0; dc < KERNEL; dc++) begin
				nr = r + dr - 1;
				nc = c + dc - 1;
				if ((nr < 0 || nr >= cfg_n || nc < 0 || nc >= cfg_n) && !cfg_pad) begin
					px = 0;
				end else begin
					nr = (nr < 0) ? 0 : ((nr >= cfg_n) ? cfg_n - 1 : nr);
					nc = (nc < 0) ? 0 : ((nc >= cfg_n) ? cfg_n - 1 : nc);
					px = img[nr * cfg_n + nc];
				end
				acc += px * filt[dr * KERNEL + dc];
			end
		end
		if (acc >= 0)
			acc = (acc > OUT_MAX) ? OUT_MAX : acc;
		else if (!cfg_act)
			acc = 0;
		else begin
			acc = acc / LEAK_DIV;
			acc = (acc < OUT_MIN) ? OUT_MIN : acc;
		end
		return OUT_W'(acc);
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_pixel(input string name, input logic signed [OUT_W-1:0] expected,
	                           input logic signed [OUT_W-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic check_count(input string name, input logic [ADDR_W:0] expected,
	                           input logic [ADDR_W:0] actual);
		if (actual !== expected)
			report_failure($sformatf("error %s word count: expected %0d, actual %0d",
			                         name, expected, actual));
	endtask

	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			if (exp_q.size() == 0)
				report_failure("out_valid was raised with no output word expected");
			else
				check_pixel($sformatf("%s[%0d]", test_name, word_cnt), exp_q.pop_front(), out_data);
			word_cnt++;
		end
	end

	// --------------------
	// load sequences
	task automatic load_filter(input int n, input bit pad, input bit act);
		cfg_n   = n;
		cfg_pad = pad;
		cfg_act = act;
		for (int i = 0; i <= TAPS; i++) begin
			@(posedge clk);
			filter_valid <= (i < TAPS);
			in_data      <= (i < TAPS) ? filt[i] : '0;
			if (i == 0) begin
				image_size <= SIZE_W'(n);
				pad_mode   <= pad;
				act_mode   <= act;
			end
		end
	endtask

	task automatic run_image(input string name);
		int total;
		total     = cfg_n * cfg_n;
		test_name = name;
		word_cnt  = 0;
		for (int r = 0; r < cfg_n; r++)
			for (int c = 0; c < cfg_n; c++)
				exp_q.push_back(conv_ref(r, c));
		for (int i = 0; i <= total; i++) begin
			@(posedge clk);
			image_valid <= (i < total);
			in_data     <= (i < total) ? img[i] : '0;
		end
		// first word 5 edges after the last pixel, then one per cycle
		repeat (total + 8) @(posedge clk);
		check_count(name, (ADDR_W + 1)'(total), (ADDR_W + 1)'(word_cnt));
	endtask

	task automatic fill_random(input int n);
		for (int k = 0; k < TAPS; k++) begin
			rng     = xorshift32(rng);
			filt[k] = rng[DATA_W-1:0];
		end
		for (int k = 0; k < n * n; k++) begin
			rng    = xorshift32(rng);
			img[k] = rng[DATA_W-1:0];
		end
	endtask

	task automatic fill_const(input logic signed [DATA_W-1:0] f, input logic signed [DATA_W-1:0] p);
		for (int k = 0; k < TAPS; k++)
			filt[k] = f;
		for (int k = 0; k < FRAME_DEPTH; k++)
			img[k] = p;
	endtask

	initial begin : watchdog
		int budget;
		budget = 5;
		foreach (FRAME_SIDES[i])
			budget += 9 + 2 * FRAME_SIDES[i] * FRAME_SIDES[i] + 10;
		repeat (2 * budget) @(posedge clk);
		report_failure("timeout: the tests did not finish in the allowed number of cycles");
	end

	initial begin
		rng      = 32'h6193_c0a8;
		word_cnt = 0;
		rst_n        <= 1'b0;
		filter_valid <= 1'b0;
		image_valid  <= 1'b0;
		image_size   <= '0;
		pad_mode     <= 1'b0;
		act_mode     <= 1'b0;
		in_data      <= '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		fill_random(5);
		load_filter(5, 1'b0, 1'b0);
		run_image("relu_zero_pad_5x5");
		fill_random(6);
		load_filter(6, 1'b1, 1'b1);
		run_image("leaky_replicate_6x6");

		// saturation corners
		fill_const(8'sd127, 8'sd127);
		load_filter(4, 1'b0, 1'b0);
		run_image("saturate_positive_4x4");
		fill_const(8'sd127, -8'sd128);
		load_filter(4, 1'b0, 1'b1);
		run_image("saturate_negative_4x4");

		for (int s = 0; s < 2; s++) begin
			for (int p = 0; p < 2; p++) begin
				fill_random(s ? 8 : 3);
				load_filter(s ? 8 : 3, p[0], p[0]);
				run_image($sformatf("size_%0d_pad_%0d", s ? 8 : 3, p));
			end
		end

		// second frame reuses coefficients and config
		fill_random(7);
		load_filter(7, 1'b1, 1'b0);
		run_image("reuse_first_7x7");
		for (int k = 0; k < 49; k++) begin
			rng    = xorshift32(rng);
			img[k] = rng[DATA_W-1:0];
		end
		run_image("reuse_second_7x7");

		$display("Verification passed");
		$finish;
	end

endmodule

// File: verilog/conv_act.sv
`timescale 1ns/10ps

module conv_act (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              sum_valid,
	input  logic signed [conv_pkg::ACC_W-1:0] sum,
	input  logic                              act_reg,
	output logic                              out_valid,
	output logic signed [conv_pkg::OUT_W-1:0] out_data
);
	import conv_pkg::*;

	logic signed [ACC_W-1:0] quot;
	logic signed [OUT_W-1:0] act_nxt;

	always_comb begin
		// signed divide truncates toward zero
		quot = ACC_W'(sum / LEAK_DIV);
		if (!sum[ACC_W-1])
			act_nxt = (sum > OUT_MAX) ? OUT_W'(OUT_MAX) : sum[OUT_W-1:0];
		else if (!act_reg)
			act_nxt = '0;
		else
			act_nxt = (quot < OUT_MIN) ? OUT_W'(OUT_MIN) : quot[OUT_W-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else begin
			out_valid <= sum_valid;
			// idle output held at zero
			out_data  <= sum_valid ? act_nxt : '0;
		end
	end

endmodule

// File: verilog/conv_mac.sv
`timescale 1ns/10ps

module conv_mac (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        coef_we,
	input  logic [conv_pkg::IDX_W-1:0]                  coef_idx,
	input  logic signed [conv_pkg::DATA_W-1:0]          in_data,
	input  logic                                        win_valid,
	input  logic [conv_pkg::TAPS*conv_pkg::DATA_W-1:0]  window,
	output logic                                        sum_valid,
	output logic signed [conv_pkg::ACC_W-1:0]           sum
);
	import conv_pkg::*;

	logic signed [DATA_W-1:0] coef [TAPS];
	logic signed [DATA_W-1:0] in_q;
	logic signed [PROD_W-1:0] prod [TAPS];
	logic signed [ACC_W-1:0]  pair [TAPS/2];
	logic signed [ACC_W-1:0]  quad [2];
	logic signed [ACC_W-1:0]  sum_nxt;
	logic                     prod_valid;

	// in_data delayed to meet the registered write strobe
	always_ff @(posedge clk) begin
		in_q <= in_data;
		if (coef_we)
			coef[coef_idx] <= in_q;
	end

	// stage one, products
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int k = 0; k < TAPS; k++)
				prod[k] <= $signed(window[k*DATA_W +: DATA_W]) * coef[k];
		end
	end

	// --------------------
	// adder tree, 9 -> 1
	always_comb begin
		for (int k = 0; k < TAPS/2; k++)
			pair[k] = prod[2*k] + prod[2*k + 1];
		quad[0] = pair[0] + pair[1];
		quad[1] = pair[2] + pair[3];
		sum_nxt = (quad[0] + quad[1]) + prod[TAPS-1];
	end

	always_ff @(posedge clk) begin
		if (prod_valid)
			sum <= sum_nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			sum_valid  <= prod_valid;
		end
	end

endmodule

// File: verilog/conv_top.sv
`timescale 1ns/10ps

module conv_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              filter_valid,
	input  logic                              image_valid,
	input  logic [conv_pkg::SIZE_W-1:0]       image_size,
	input  logic                              pad_mode,
	input  logic                              act_mode,
	input  logic signed [conv_pkg::DATA_W-1:0] in_data,
	output logic                              out_valid,
	output logic signed [conv_pkg::OUT_W-1:0] out_data
);
	import conv_pkg::*;

	logic                     coef_we;
	logic [IDX_W-1:0]         coef_idx;
	logic                     pix_we;
	logic [ADDR_W-1:0]        pix_addr;
	logic                     scan_valid;
	logic [COORD_W-1:0]       scan_row;
	logic [COORD_W-1:0]       scan_col;
	logic [SIZE_W-1:0]        size_reg;
	logic                     pad_reg;
	logic                     act_reg;
	logic                     win_valid;
	logic [TAPS*DATA_W-1:0]   window;
	logic                     sum_valid;
	logic signed [ACC_W-1:0]  sum;

	conv_ctrl conv_ctrl_inst (
		.clk, .rst_n, .filter_valid, .image_valid, .image_size, .pad_mode, .act_mode,
		.coef_we, .coef_idx, .pix_we, .pix_addr,
		.scan_valid, .scan_row, .scan_col, .size_reg, .pad_reg, .act_reg
	);

	conv_frame conv_frame_inst (
		.clk, .rst_n, .pix_we, .pix_addr, .in_data,
		.scan_valid, .scan_row, .scan_col, .size_reg, .pad_reg,
		.win_valid, .window
	);

	conv_mac conv_mac_inst (
		.clk, .rst_n, .coef_we, .coef_idx, .in_data,
		.win_valid, .window, .sum_valid, .sum
	);

	conv_act conv_act_inst (
		.clk, .rst_n, .sum_valid, .sum, .act_reg,
		.out_valid, .out_data
	);

endmodule
